/* include/chirp_capture_macros.svh */
`ifndef CHIRP_CAPTURE_MACROS_SVH
`define CHIRP_CAPTURE_MACROS_SVH

// sample and capture word widths
`define SAMPLE_W 16
`define WORD_W 64
`define HALF_W 32

// dds pipeline latency in clock cycles
`define DDS_LATENCY 2
`define LOOPBACK_DELAY 100
`define TIMER_W 4

`endif

/* rtl/capture_counters.sv */
`timescale 1ns/1ps

`include "chirp_capture_macros.svh"

module capture_counters (
  input  logic               clk_245_76MHz,
  input  logic               cpu_reset,
  input  logic               count_en_i,
  output logic [`HALF_W-1:0] sample_count_o,
  output logic [`HALF_W-1:0] time_count_o
);

  logic [`HALF_W-1:0] sample_count;
  logic [`WORD_W-1:0] time_count;

  // captured words, accumulated over all captures since reset
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_count <= '0;
    end else if (count_en_i) begin
      sample_count <= sample_count + 1'b1;
    end
  end

  // free running timestamp
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      time_count <= '0;
    end else begin
      time_count <= time_count + 1'b1;
    end
  end

  assign sample_count_o = sample_count;
  // only the low half goes into capture words
  assign time_count_o   = time_count[`HALF_W-1:0];

endmodule

/* rtl/capture_fsm.sv */
`timescale 1ns/1ps

module capture_fsm
  import chirp_capture_pkg::*;
(
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  logic capture_enable_i,
  input  logic chirp_init_i,
  input  logic timer_busy_i,
  output logic timer_load_o,
  output logic capture_valid_o,
  output logic capture_first_o,
  output logic capture_last_o
);

  capture_state_t state;
  capture_state_t state_next;
  logic           enable_r;
  logic           open_capture;
  logic           close_capture;

  // restart the latency timer on a new chirp or when the enable drops
  assign timer_load_o = chirp_init_i | (enable_r & ~capture_enable_i);

  assign open_capture  = (state == CAP_IDLE) & ~timer_busy_i & enable_r;
  assign close_capture = (state == CAP_ACTIVE) & ~timer_busy_i & ~enable_r;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r <= 1'b0;
    end else begin
      enable_r <= capture_enable_i;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      CAP_IDLE:   if (open_capture) state_next = CAP_ACTIVE;
      CAP_ACTIVE: if (close_capture) state_next = CAP_IDLE;
      default:    state_next = CAP_IDLE;
    endcase
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state           <= CAP_IDLE;
      capture_first_o <= 1'b0;
    end else begin
      state           <= state_next;
      // high only in the first active cycle
      capture_first_o <= open_capture;
    end
  end

  assign capture_valid_o = (state == CAP_ACTIVE);
  // last word is flagged in the cycle the window closes
  assign capture_last_o  = close_capture;

endmodule

/* rtl/chirp_capture_pkg.sv */
`include "chirp_capture_macros.svh"

package chirp_capture_pkg;

  // capture window state
  typedef enum logic {
    CAP_IDLE   = 1'b0,
    CAP_ACTIVE = 1'b1
  } capture_state_t;

  // source select for one half of a capture word
  typedef enum logic [1:0] {
    ROUTE_ADC          = 2'd0,
    ROUTE_DAC          = 2'd1,
    ROUTE_SAMPLE_COUNT = 2'd2,
    ROUTE_TIME         = 2'd3
  } route_sel_t;

  typedef logic signed [`SAMPLE_W-1:0] sample_t;

endpackage

/* rtl/chirp_capture_top.sv */
`timescale 1ns/1ps

`include "chirp_capture_macros.svh"

module chirp_capture_top
  import chirp_capture_pkg::*;
(
  input  logic               clk_245_76MHz,
  input  logic               cpu_reset,
  input  sample_t            dds_i_i,
  input  sample_t            dds_q_i,
  input  logic               capture_enable_i,
  input  logic               chirp_init_i,
  input  route_sel_t         route_lower_i,
  input  route_sel_t         route_upper_i,
  output logic [`WORD_W-1:0] word_o,
  output logic               word_valid_o,
  output logic               word_first_o,
  output logic               word_last_o
);

  logic               timer_load;
  logic               timer_busy;
  logic               capture_valid;
  logic               capture_first;
  logic               capture_last;
  logic [`HALF_W-1:0] sample_count;
  logic [`HALF_W-1:0] time_count;
  sample_t            dac_i;
  sample_t            dac_q;
  sample_t            adc_i;
  sample_t            adc_q;

  capture_fsm u_capture_fsm (
    .clk_245_76MHz    (clk_245_76MHz),
    .cpu_reset        (cpu_reset),
    .capture_enable_i (capture_enable_i),
    .chirp_init_i     (chirp_init_i),
    .timer_busy_i     (timer_busy),
    .timer_load_o     (timer_load),
    .capture_valid_o  (capture_valid),
    .capture_first_o  (capture_first),
    .capture_last_o   (capture_last)
  );

  latency_timer u_latency_timer (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .load_i        (timer_load),
    .busy_o        (timer_busy)
  );

  capture_counters u_capture_counters (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .count_en_i     (capture_valid),
    .sample_count_o (sample_count),
    .time_count_o   (time_count)
  );

  // stands in for the dac to adc loopback cable
  dds_loopback u_dds_loopback (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .dds_i_i       (dds_i_i),
    .dds_q_i       (dds_q_i),
    .dac_i_o       (dac_i),
    .dac_q_o       (dac_q),
    .adc_i_o       (adc_i),
    .adc_q_o       (adc_q)
  );

  frame_builder u_frame_builder (
    .route_lower_i   (route_lower_i),
    .route_upper_i   (route_upper_i),
    .capture_first_i (capture_first),
    .capture_last_i  (capture_last),
    .sample_count_i  (sample_count),
    .time_count_i    (time_count),
    .dac_i_i         (dac_i),
    .dac_q_i         (dac_q),
    .adc_i_i         (adc_i),
    .adc_q_i         (adc_q),
    .word_o          (word_o)
  );

  assign word_valid_o = capture_valid;
  assign word_first_o = capture_first;
  assign word_last_o  = capture_last;

endmodule

/* rtl/dds_loopback.sv */
`timescale 1ns/1ps

`include "chirp_capture_macros.svh"

module dds_loopback
  import chirp_capture_pkg::*;
(
  input  logic    clk_245_76MHz,
  input  logic    cpu_reset,
  input  sample_t dds_i_i,
  input  sample_t dds_q_i,
  output sample_t dac_i_o,
  output sample_t dac_q_o,
  output sample_t adc_i_o,
  output sample_t adc_q_o
);

  sample_t dac_i_r;
  sample_t dac_q_r;
  sample_t adc_i_dly [`LOOPBACK_DELAY];
  sample_t adc_q_dly [`LOOPBACK_DELAY];

  // dac output register
  always_ff @(posedge clk_245_76MHz) begin
    dac_i_r <= dds_i_i;
    dac_q_r <= dds_q_i;
  end

  // analog path: half amplitude, long propagation delay
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int i = 0; i < `LOOPBACK_DELAY; i++) begin
        adc_i_dly[i] <= '0;
        adc_q_dly[i] <= '0;
      end
    end else begin
      adc_i_dly[0] <= dac_i_r >>> 1;
      adc_q_dly[0] <= dac_q_r >>> 1;
      for (int i = 1; i < `LOOPBACK_DELAY; i++) begin
        adc_i_dly[i] <= adc_i_dly[i-1];
        adc_q_dly[i] <= adc_q_dly[i-1];
      end
    end
  end

  assign dac_i_o = dac_i_r;
  assign dac_q_o = dac_q_r;
  assign adc_i_o = adc_i_dly[`LOOPBACK_DELAY-1];
  assign adc_q_o = adc_q_dly[`LOOPBACK_DELAY-1];

endmodule

/* rtl/frame_builder.sv */
`timescale 1ns/1ps

`include "chirp_capture_macros.svh"

module frame_builder
  import chirp_capture_pkg::*;
(
  input  route_sel_t         route_lower_i,
  input  route_sel_t         route_upper_i,
  input  logic               capture_first_i,
  input  logic               capture_last_i,
  input  logic [`HALF_W-1:0] sample_count_i,
  input  logic [`HALF_W-1:0] time_count_i,
  input  sample_t            dac_i_i,
  input  sample_t            dac_q_i,
  input  sample_t            adc_i_i,
  input  sample_t            adc_q_i,
  output logic [`WORD_W-1:0] word_o
);

  logic [`HALF_W-1:0] half_lower;
  logic [`HALF_W-1:0] half_upper;

  // one word half, i in the upper sample slot
  function automatic logic [`HALF_W-1:0] pick_half(input route_sel_t sel);
    logic [`HALF_W-1:0] result;
    case (sel)
      ROUTE_ADC:          result = {adc_i_i, adc_q_i};
      ROUTE_DAC:          result = {dac_i_i, dac_q_i};
      ROUTE_SAMPLE_COUNT: result = sample_count_i;
      ROUTE_TIME:         result = time_count_i;
      default:            result = {adc_i_i, adc_q_i};
    endcase
    return result;
  endfunction

  // sources are read inside the function, so the mux needs full sensitivity
  always_comb begin
    half_lower = pick_half(route_lower_i);
    half_upper = pick_half(route_upper_i);
  end

  // timestamp pair replaces data on the boundary words
  always_comb begin
    if (capture_first_i | capture_last_i) begin
      word_o = {time_count_i, sample_count_i};
    end else begin
      word_o = {half_upper, half_lower};
    end
  end

endmodule

/* rtl/latency_timer.sv */
`timescale 1ns/1ps

`include "chirp_capture_macros.svh"

module latency_timer (
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  logic load_i,
  output logic busy_o
);

  logic [`TIMER_W-1:0] count;

  // covers samples still in flight through the dds pipeline
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      count <= '0;
    end else if (load_i) begin
      count <= `TIMER_W'(`DDS_LATENCY);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign busy_o = (count != '0);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_chirp_capture -o sim_chirp_capture

# keep going after a non-zero exit so the log decides the result
./obj_dir/sim_chirp_capture 2>&1 | tee "$LOG" || true

if grep -q "tests failed" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation finished without failures"
exit 0

/* src.f */
+incdir+include
rtl/chirp_capture_pkg.sv
rtl/capture_fsm.sv
rtl/latency_timer.sv
rtl/capture_counters.sv
rtl/dds_loopback.sv
rtl/frame_builder.sv
rtl/chirp_capture_top.sv
test/tb_chirp_capture.sv

/* test/tb_chirp_capture.sv */
`timescale 1ns/1ps

`include "chirp_capture_macros.svh"

module tb_chirp_capture
  import chirp_capture_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES  = 20;
  localparam int CAP_TAIL     = `DDS_LATENCY + 4;
  // every next_cycle call made by the tests below
  localparam int STIM_CYCLES  = RESET_CYCLES + IDLE_CYCLES + (6 + CAP_TAIL) + (5 + CAP_TAIL)
                                + (`LOOPBACK_DELAY + 10) + (8 + CAP_TAIL) + (6 + CAP_TAIL)
                                + (1 + 6 + CAP_TAIL);
  localparam int WATCHDOG_CYCLES = STIM_CYCLES + `LOOPBACK_DELAY + 200;

  logic               clk_245_76MHz = 1'b0;
  logic               cpu_reset;
  sample_t            dds_i_i;
  sample_t            dds_q_i;
  logic               capture_enable_i;
  logic               chirp_init_i;
  route_sel_t         route_lower_i;
  route_sel_t         route_upper_i;
  logic [`WORD_W-1:0] word_o;
  logic               word_valid_o;
  logic               word_first_o;
  logic               word_last_o;

  // reference model state
  sample_t            hist_i[$];
  sample_t            hist_q[$];
  int                 cyc;
  int                 valid_count;
  logic [31:0]        lfsr;
  logic [`WORD_W-1:0] obs_word;
  logic               obs_valid;
  logic               obs_first;
  logic               obs_last;

  chirp_capture_top i_dut (
    .clk_245_76MHz    (clk_245_76MHz),
    .cpu_reset        (cpu_reset),
    .dds_i_i          (dds_i_i),
    .dds_q_i          (dds_q_i),
    .capture_enable_i (capture_enable_i),
    .chirp_init_i     (chirp_init_i),
    .route_lower_i    (route_lower_i),
    .route_upper_i    (route_upper_i),
    .word_o           (word_o),
    .word_valid_o     (word_valid_o),
    .word_first_o     (word_first_o),
    .word_last_o      (word_last_o)
  );

  always #(CLK_PERIOD / 2) clk_245_76MHz = ~clk_245_76MHz;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_sample(output sample_t s);
    for (int b = 0; b < `SAMPLE_W; b++) begin
      lfsr = lfsr_next(lfsr);
      s = {s[`SAMPLE_W-2:0], lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("ERROR t=%0t signal=%s expected=0x%0h actual=0x%0h", $time, name, expected, actual);
    $display("tests failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else report_mismatch(name, 64'(expected), 64'(actual));
  endtask

  task automatic check_half(input string name, input logic [`HALF_W-1:0] expected,
                            input logic [`HALF_W-1:0] actual);
    assert (actual === expected) else report_mismatch(name, 64'(expected), 64'(actual));
  endtask

  // sample outputs at the falling edge, then drive the next inputs
  task automatic next_cycle(input logic en, input logic init);
    sample_t si;
    sample_t sq;
    @(negedge clk_245_76MHz);
    obs_word  = word_o;
    obs_valid = word_valid_o;
    obs_first = word_first_o;
    obs_last  = word_last_o;
    cyc = hist_i.size();
    random_sample(si);
    random_sample(sq);
    hist_i.push_back(si);
    hist_q.push_back(sq);
    dds_i_i          = si;
    dds_q_i          = sq;
    capture_enable_i = en;
    chirp_init_i     = init;
  endtask

  function automatic logic [`HALF_W-1:0] expected_half(input route_sel_t sel, input int offset,
                                                       input logic [`HALF_W-1:0] first_time);
    logic [`HALF_W-1:0] result;
    case (sel)
      ROUTE_DAC: result = {hist_i[cyc-1], hist_q[cyc-1]};
      ROUTE_ADC: begin
        result = {hist_i[cyc-1-`LOOPBACK_DELAY] >>> 1, hist_q[cyc-1-`LOOPBACK_DELAY] >>> 1};
      end
      ROUTE_SAMPLE_COUNT: result = 32'(valid_count);
      ROUTE_TIME:         result = first_time + 32'(offset);
      default:            result = '0;
    endcase
    return result;
  endfunction

  // enable for n sampled edges, optionally after a chirp start one cycle earlier
  task automatic run_capture(input int n, input logic pre_init, input logic check_data);
    int                 first_i;
    int                 last_i;
    int                 length;
    logic               exp_valid;
    logic [`HALF_W-1:0] first_upper;
    logic [`HALF_W-1:0] first_lower;
    first_i     = pre_init ? (`DDS_LATENCY + 1) : 2;
    last_i      = n + `DDS_LATENCY + 1;
    length      = last_i - first_i + 1;
    first_upper = '0;
    first_lower = '0;
    if (pre_init) begin
      next_cycle(1'b0, 1'b1);
    end
    for (int i = 0; i < n + CAP_TAIL; i++) begin
      next_cycle(i < n, 1'b0);
      exp_valid = (i >= first_i) && (i <= last_i);
      check_bit("word_valid_o", exp_valid, obs_valid);
      check_bit("word_first_o", i == first_i, obs_first);
      check_bit("word_last_o", i == last_i, obs_last);
      if (i == first_i) begin
        first_upper = obs_word[63:32];
        first_lower = obs_word[31:0];
        check_half("word_o[31:0] first", 32'(valid_count), obs_word[31:0]);
      end else if (i == last_i) begin
        check_half("word_o[31:0] last", 32'(valid_count), obs_word[31:0]);
        check_half("word_o[31:0] last step", first_lower + 32'(length - 1), obs_word[31:0]);
        check_half("word_o[63:32] last", first_upper + 32'(length - 1), obs_word[63:32]);
      end else if (exp_valid && check_data) begin
        check_half("word_o[31:0]", expected_half(route_lower_i, i - first_i, first_upper),
                   obs_word[31:0]);
        check_half("word_o[63:32]", expected_half(route_upper_i, i - first_i, first_upper),
                   obs_word[63:32]);
      end
      if (obs_valid) begin
        valid_count++;
      end
    end
  endtask

  task automatic test_reset_state();
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      next_cycle(1'b0, 1'b0);
      check_bit("word_valid_o", 1'b0, obs_valid);
      check_bit("word_first_o", 1'b0, obs_first);
      check_bit("word_last_o", 1'b0, obs_last);
    end
  endtask

  task automatic test_capture_length();
    run_capture(6, 1'b0, 1'b0);
  endtask

  task automatic test_timestamps();
    run_capture(5, 1'b0, 1'b0);
  endtask

  task automatic test_routing();
    route_lower_i = ROUTE_DAC;
    route_upper_i = ROUTE_ADC;
    // let the adc delay line fill with known samples
    repeat (`LOOPBACK_DELAY + 10) next_cycle(1'b0, 1'b0);
    run_capture(8, 1'b0, 1'b1);
  endtask

  task automatic test_counter_sources();
    route_lower_i = ROUTE_SAMPLE_COUNT;
    route_upper_i = ROUTE_TIME;
    run_capture(6, 1'b0, 1'b1);
    // chirp start one cycle ahead delays the opening of the window
    run_capture(6, 1'b1, 1'b1);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the directed tests did not complete within the expected time");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    cpu_reset        = 1'b1;
    dds_i_i          = '0;
    dds_q_i          = '0;
    capture_enable_i = 1'b0;
    chirp_init_i     = 1'b0;
    route_lower_i    = ROUTE_ADC;
    route_upper_i    = ROUTE_ADC;
    cyc              = 0;
    valid_count      = 0;
    lfsr             = 32'ha0ea;
    repeat (RESET_CYCLES) next_cycle(1'b0, 1'b0);
    cpu_reset = 1'b0;
    test_reset_state();
    test_capture_length();
    test_timestamps();
    test_routing();
    test_counter_sources();
    $display("all tests passed");
    $finish;
  end

endmodule
